/* rtl/div_pkg.sv */
`default_nettype none

package div_pkg;

   localparam int div_width   = 32;
   localparam int div_steps   = 32;   // quotient iterations, remainder adds one
   localparam int small_width = 4;

   // operands and result
   typedef logic [div_width-1:0] div_word_t;

   // divisor with sign extension, partial remainder, quotient register
   typedef logic [div_width:0] div_ext_t;

   typedef logic [5:0] div_count_t;   // holds up to div_steps + 1

   typedef logic [small_width-1:0] div_small_t;

   typedef struct packed {
      logic is_unsigned;
      logic is_rem;
   } div_cmd_t;

   // captured with the operands
   typedef struct packed {
      logic dividend_neg;
      logic divisor_neg;
      logic signed_op;     // signed and divisor nonzero
      logic is_rem;
   } div_flags_t;

endpackage

`default_nettype wire

/* rtl/div_control.sv */
`timescale 1ns/1ps
`default_nettype none

module div_control import div_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       start,
   input  wire logic       cancel,
   input  wire div_flags_t flags,
   input  wire logic       small_hit,
   output logic            run,
   output logic            first_step,
   output logic            last_step,
   output logic            done
);

   logic       run_ff;
   logic       first_ff;
   logic       finish;
   logic       finish_ff;
   logic       count_en;
   div_count_t count;

   // remainder needs one extra pass for the correction
   assign finish = small_hit |
                   (flags.is_rem ? (count == div_count_t'(div_steps + 1))
                                 : (count == div_count_t'(div_steps)));

   assign count_en = run_ff & ~finish & ~cancel;

   always_ff @(posedge clk) begin
      if (reset) begin
         run_ff    <= 1'b0;
         first_ff  <= 1'b0;
         finish_ff <= 1'b0;
         count     <= '0;
      end else begin
         run_ff    <= (start | run_ff) & ~finish & ~cancel;
         first_ff  <= start & ~cancel;
         finish_ff <= finish & ~cancel;
         if (count_en) begin
            count <= count + div_count_t'(1);
         end else begin
            count <= '0;   // idle or killed
         end
      end
   end

   assign run        = run_ff;
   assign first_step = first_ff;
   assign last_step  = (count == div_count_t'(div_steps + 1));

   // late cancel still kills the pulse
   assign done = finish_ff & ~cancel;

endmodule

`default_nettype wire

/* rtl/div_smallnum.sv */
`timescale 1ns/1ps
`default_nettype none

module div_smallnum import div_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       step_valid,
   input  wire div_flags_t flags,
   input  wire div_small_t q_low,
   input  wire div_small_t m_low,
   input  wire logic       q_high_zero,
   input  wire logic       m_high_zero,
   input  wire logic       dividend_zero,
   input  wire logic       divisor_zero,
   output logic            small_hit,
   output logic            small_hit_ff,
   output div_small_t      small_q_ff
);

   div_small_t small_q;

   // both fit in 4 bits, or dividend is zero; divide by zero goes long
   assign small_hit = step_valid & ~flags.is_rem & ~divisor_zero &
                      ((q_high_zero & m_high_zero) | dividend_zero);

   // m_low may be zero with a big divisor, quotient is unused then
   assign small_q = (m_low == '0) ? '0 : div_small_t'(q_low / m_low);

   always_ff @(posedge clk) begin
      if (reset) begin
         small_hit_ff <= 1'b0;
      end else begin
         small_hit_ff <= small_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (small_hit) begin
         small_q_ff <= small_q;
      end
   end

endmodule

`default_nettype wire

/* rtl/div_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module div_datapath import div_pkg::*; (
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      start,
   input  wire div_cmd_t  cmd,
   input  wire div_word_t dividend,
   input  wire div_word_t divisor,
   input  wire logic      run,
   input  wire logic      first_step,
   input  wire logic      last_step,
   output div_flags_t     flags,
   output div_ext_t       q_ff,
   output div_ext_t       a_ff,
   output div_small_t     q_low,
   output div_small_t     m_low,
   output logic           q_high_zero,
   output logic           m_high_zero,
   output logic           dividend_zero,
   output logic           divisor_zero
);

   div_ext_t   m_ff;
   div_ext_t   m_eff;
   div_ext_t   a_shift;
   div_ext_t   a_next;
   div_word_t  dividend_eff;
   div_flags_t flags_next;
   logic       add;
   logic       m_already_comp;
   logic       rem_correct;
   logic       a_en;

   always_comb begin
      flags_next.dividend_neg = dividend[div_width-1];
      flags_next.divisor_neg  = divisor[div_width-1];
      flags_next.signed_op    = ~cmd.is_unsigned & (divisor != '0);
      flags_next.is_rem       = cmd.is_rem;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (start) begin
         flags <= flags_next;
      end
   end

   // divisor sign extended only for signed ops
   always_ff @(posedge clk) begin
      if (start) begin
         m_ff <= {~cmd.is_unsigned & divisor[div_width-1], divisor};
      end
   end

   // magnitude of a negative signed dividend
   assign dividend_eff = (flags.signed_op & flags.dividend_neg) ? -q_ff[div_width-1:0]
                                                                 : q_ff[div_width-1:0];

   // negative divisor is already complemented, so swap add and sub
   assign m_already_comp = flags.divisor_neg & flags.signed_op;

   assign rem_correct = last_step & flags.is_rem & a_ff[div_width];

   assign add = a_ff[div_width] ^ m_already_comp;

   assign m_eff = add ? m_ff : ~m_ff;

   // correction pass adds back without a shift
   assign a_shift = rem_correct ? a_ff : {a_ff[div_width-1:0], q_ff[div_width]};

   assign a_next = a_shift + m_eff + {{div_width{1'b0}}, ~add};

   always_ff @(posedge clk) begin
      if (start) begin
         q_ff <= {1'b0, dividend};
      end else if (run) begin
         if (first_step) begin
            q_ff <= {dividend_eff, ~a_next[div_width]};
         end else begin
            q_ff <= {q_ff[div_width-1:0], ~a_next[div_width]};
         end
      end
   end

   // remainder holds in the last pass unless it went negative
   assign a_en = (run & ~last_step) | rem_correct;

   always_ff @(posedge clk) begin
      if (start) begin
         a_ff <= '0;
      end else if (a_en) begin
         a_ff <= a_next;
      end
   end

   // zero tests for the short path, off the raw operands
   assign q_high_zero   = (q_ff[div_width-1:small_width] == '0);
   assign m_high_zero   = (m_ff[div_width-1:small_width] == '0);
   assign dividend_zero = (q_ff[div_width-1:0] == '0);
   assign divisor_zero  = (m_ff[div_width-1:0] == '0);

   assign q_low = q_ff[small_width-1:0];
   assign m_low = m_ff[small_width-1:0];

endmodule

`default_nettype wire

/* rtl/div_result.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result import div_pkg::*; (
   input  wire div_flags_t flags,
   input  wire div_ext_t   q_ff,
   input  wire div_ext_t   a_ff,
   input  wire logic       small_hit_ff,
   input  wire div_small_t small_q_ff,
   output div_word_t       result
);

   div_word_t q_eff;
   div_word_t a_eff;
   logic      q_negate;
   logic      a_negate;

   assign q_negate = flags.signed_op & (flags.dividend_neg ^ flags.divisor_neg);

   // remainder follows the dividend sign
   assign a_negate = flags.signed_op & flags.dividend_neg;

   assign q_eff = q_negate ? -q_ff[div_width-1:0] : q_ff[div_width-1:0];
   assign a_eff = a_negate ? -a_ff[div_width-1:0] : a_ff[div_width-1:0];

   always_comb begin
      if (small_hit_ff) begin
         result = {{(div_width - small_width){1'b0}}, small_q_ff};
      end else if (flags.is_rem) begin
         result = a_eff;
      end else begin
         result = q_eff;
      end
   end

endmodule

`default_nettype wire

/* rtl/div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_top import div_pkg::*; (
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      start,
   input  wire div_cmd_t  cmd,
   input  wire div_word_t dividend,
   input  wire div_word_t divisor,
   input  wire logic      cancel,
   output logic           done,
   output div_word_t      result
);

   div_flags_t flags;
   div_ext_t   q_ff;
   div_ext_t   a_ff;
   div_small_t q_low;
   div_small_t m_low;
   div_small_t small_q_ff;
   logic       q_high_zero;
   logic       m_high_zero;
   logic       dividend_zero;
   logic       divisor_zero;
   logic       run;
   logic       first_step;
   logic       last_step;
   logic       step_valid;
   logic       small_hit;
   logic       small_hit_ff;

   assign step_valid = first_step & ~cancel;   // short path only on a live divide

   div_control i_div_control (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .cancel     (cancel),
      .flags      (flags),
      .small_hit  (small_hit),
      .run        (run),
      .first_step (first_step),
      .last_step  (last_step),
      .done       (done)
   );

   div_smallnum i_div_smallnum (
      .clk           (clk),
      .reset         (reset),
      .step_valid    (step_valid),
      .flags         (flags),
      .q_low         (q_low),
      .m_low         (m_low),
      .q_high_zero   (q_high_zero),
      .m_high_zero   (m_high_zero),
      .dividend_zero (dividend_zero),
      .divisor_zero  (divisor_zero),
      .small_hit     (small_hit),
      .small_hit_ff  (small_hit_ff),
      .small_q_ff    (small_q_ff)
   );

   div_datapath i_div_datapath (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .cmd           (cmd),
      .dividend      (dividend),
      .divisor       (divisor),
      .run           (run),
      .first_step    (first_step),
      .last_step     (last_step),
      .flags         (flags),
      .q_ff          (q_ff),
      .a_ff          (a_ff),
      .q_low         (q_low),
      .m_low         (m_low),
      .q_high_zero   (q_high_zero),
      .m_high_zero   (m_high_zero),
      .dividend_zero (dividend_zero),
      .divisor_zero  (divisor_zero)
   );

   div_result i_div_result (
      .flags        (flags),
      .q_ff         (q_ff),
      .a_ff         (a_ff),
      .small_hit_ff (small_hit_ff),
      .small_q_ff   (small_q_ff),
      .result       (result)
   );

endmodule

`default_nettype wire

/* verif/div_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_tb import div_pkg::*; ();

   localparam int         done_timeout = 40;
   localparam div_count_t lat_quot     = div_count_t'(div_steps + 1);
   localparam div_count_t lat_rem      = div_count_t'(div_steps + 2);
   localparam div_count_t lat_short    = div_count_t'(1);

   // cmd bits are {is_unsigned, is_rem}
   localparam div_cmd_t op_div  = 2'b00;
   localparam div_cmd_t op_rem  = 2'b01;
   localparam div_cmd_t op_divu = 2'b10;
   localparam div_cmd_t op_remu = 2'b11;

   typedef struct packed {
      div_word_t  dividend;
      div_word_t  divisor;
      div_cmd_t   cmd;
      logic       has_cancel;
      div_count_t cancel_at;   // cycle offset from the start cycle
      div_word_t  expected;
      div_count_t latency;     // edges from the one that samples start
   } row_t;

   logic      clk;
   logic      reset;
   logic      start;
   div_cmd_t  cmd;
   div_word_t dividend;
   div_word_t divisor;
   logic      cancel;
   logic      done;
   div_word_t result;

   row_t   rows[$];
   integer seed;

   div_top i_div_top (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .cmd      (cmd),
      .dividend (dividend),
      .divisor  (divisor),
      .cancel   (cancel),
      .done     (done),
      .result   (result)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_result(input div_word_t got, input div_word_t expected, input int idx);
      if (got !== expected) begin
         abort_run($sformatf("mismatch at %0t: result got %h expected %h (row %0d)",
                             $time, got, expected, idx));
      end
   endtask

   task automatic check_latency(input div_count_t got, input div_count_t expected,
                                input int idx);
      if (got !== expected) begin
         abort_run($sformatf("mismatch at %0t: latency got %0d expected %0d (row %0d)",
                             $time, got, expected, idx));
      end
   endtask

   // RISC-V divide rules, truncating toward zero
   function automatic div_word_t expected_result(input div_word_t a, input div_word_t b,
                                                 input div_cmd_t op);
      logic signed [31:0] sa;
      logic signed [31:0] sb;
      sa = a;
      sb = b;
      if (b == 32'd0) begin
         return op.is_rem ? a : 32'hFFFF_FFFF;
      end
      if (op.is_unsigned) begin
         return op.is_rem ? (a % b) : (a / b);
      end
      if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
         return op.is_rem ? 32'd0 : a;   // overflow
      end
      return op.is_rem ? div_word_t'(sa % sb) : div_word_t'(sa / sb);
   endfunction

   function automatic div_count_t expected_latency(input div_word_t a, input div_word_t b,
                                                   input div_cmd_t op);
      if (op.is_rem) begin
         return lat_rem;
      end
      if (b != 32'd0 && ((a < 32'd16 && b < 32'd16) || a == 32'd0)) begin
         return lat_short;
      end
      return lat_quot;
   endfunction

   task automatic add_row(input div_word_t a, input div_word_t b, input div_cmd_t op,
                          input div_word_t exp, input div_count_t lat);
      row_t r;
      r = '0;
      r.dividend = a;
      r.divisor  = b;
      r.cmd      = op;
      r.expected = exp;
      r.latency  = lat;
      rows.push_back(r);
   endtask

   task automatic queue_cancel(input div_word_t a, input div_word_t b, input div_cmd_t op,
                               input div_count_t at);
      row_t r;
      r = '0;
      r.dividend   = a;
      r.divisor    = b;
      r.cmd        = op;
      r.has_cancel = 1'b1;
      r.cancel_at  = at;
      rows.push_back(r);
   endtask

   task automatic build_directed_rows();
      // mixed signs, long path
      add_row(32'd100,        32'd7,          op_div,  32'd14,         lat_quot);
      add_row(32'hFFFF_FF9C,  32'd7,          op_div,  32'hFFFF_FFF2,  lat_quot);
      add_row(32'd100,        32'hFFFF_FFF9,  op_div,  32'hFFFF_FFF2,  lat_quot);
      add_row(32'hFFFF_FF9C,  32'hFFFF_FFF9,  op_div,  32'd14,         lat_quot);
      add_row(32'hFFFF_FF9C,  32'd7,          op_rem,  32'hFFFF_FFFE,  lat_rem);
      add_row(32'd100,        32'hFFFF_FFF9,  op_rem,  32'd2,          lat_rem);
      add_row(32'hFFFF_FF9C,  32'hFFFF_FFF9,  op_rem,  32'hFFFF_FFFE,  lat_rem);
      add_row(32'hFFFF_FFF0,  32'd3,          op_divu, 32'h5555_5550,  lat_quot);
      add_row(32'hFFFF_FFFF,  32'd10,         op_remu, 32'd5,          lat_rem);
      add_row(32'h8000_0000,  32'h8000_0000,  op_divu, 32'd1,          lat_quot);
      // short path, small remainders stay long
      add_row(32'd13,         32'd4,          op_div,  32'd3,          lat_short);
      add_row(32'd15,         32'd1,          op_divu, 32'd15,         lat_short);
      add_row(32'd0,          32'h1234_5678,  op_div,  32'd0,          lat_short);
      add_row(32'd0,          32'hFFFF_FFFB,  op_div,  32'd0,          lat_short);
      add_row(32'd5,          32'd9,          op_div,  32'd0,          lat_short);
      add_row(32'd13,         32'd4,          op_rem,  32'd1,          lat_rem);
      add_row(32'd7,          32'd3,          op_remu, 32'd1,          lat_rem);
      // divide by zero and overflow
      add_row(32'd1234,       32'd0,          op_div,  32'hFFFF_FFFF,  lat_quot);
      add_row(32'd0,          32'd0,          op_divu, 32'hFFFF_FFFF,  lat_quot);
      add_row(32'hFFFF_FFF7,  32'd0,          op_rem,  32'hFFFF_FFF7,  lat_rem);
      add_row(32'd5,          32'd0,          op_remu, 32'd5,          lat_rem);
      add_row(32'h8000_0000,  32'hFFFF_FFFF,  op_div,  32'h8000_0000,  lat_quot);
      add_row(32'h8000_0000,  32'hFFFF_FFFF,  op_rem,  32'd0,          lat_rem);
      add_row(32'h8000_0000,  32'd1,          op_div,  32'h8000_0000,  lat_quot);
      // cancel, then a clean divide
      queue_cancel(32'd1000,  32'd3,          op_div,  div_count_t'(5));
      add_row(32'd1000,       32'd3,          op_div,  32'd333,        lat_quot);
      queue_cancel(32'd1000,  32'd7,          op_rem,  div_count_t'(0));
      add_row(32'd1000,       32'd7,          op_rem,  32'd6,          lat_rem);
      queue_cancel(32'hFFFF,  32'd17,         op_divu, div_count_t'(33));
      add_row(32'd12,         32'd5,          op_divu, 32'd2,          lat_short);
      queue_cancel(32'd5000,  32'd9,          op_remu, div_count_t'(20));
      add_row(32'd5000,       32'd9,          op_remu, 32'd5,          lat_rem);
   endtask

   task automatic build_random_rows(input int count);
      div_word_t   a;
      div_word_t   b;
      div_cmd_t    op;
      logic [31:0] shape;
      for (int i = 0; i < count; i++) begin
         a     = $random(seed);
         b     = $random(seed);
         shape = $random(seed);
         op    = shape[9:8];
         case (shape[2:0])
            3'd0: begin
               a = a & 32'hF;   // short path candidates
               b = b & 32'hF;
            end
            3'd1: b = 32'd0;
            3'd2: b = b >> shape[7:3];
            3'd3: begin
               a = 32'h8000_0000;
               b = 32'hFFFF_FFFF;
            end
            3'd4: a = 32'd0;
            default: ;
         endcase
         add_row(a, b, op, expected_result(a, b, op), expected_latency(a, b, op));
      end
   endtask

   task automatic apply_row(input row_t r, input int idx);
      int         c;
      logic       seen;
      div_count_t lat;
      div_word_t  got;
      seen = 1'b0;
      lat  = '0;
      got  = '0;
      c    = 0;
      @(posedge clk);
      start    <= 1'b1;
      cmd      <= r.cmd;
      dividend <= r.dividend;
      divisor  <= r.divisor;
      cancel   <= r.has_cancel && (r.cancel_at == 0);
      // cycle c follows edge c-1, edge 0 samples start
      while (!seen && c < done_timeout) begin
         c = c + 1;
         @(posedge clk);
         start  <= 1'b0;
         cancel <= r.has_cancel && (r.cancel_at == c);
         @(negedge clk);
         if (done) begin
            seen = 1'b1;
            lat  = div_count_t'(c - 1);
            got  = result;
         end
      end
      if (r.has_cancel) begin
         if (seen) begin
            abort_run($sformatf("row %0d: done was raised after the divide was cancelled",
                                idx));
         end
      end else begin
         if (!seen) begin
            abort_run($sformatf("row %0d: timeout, done never arrived", idx));
         end
         check_result(got, r.expected, idx);
         check_latency(lat, r.latency, idx);
      end
      @(posedge clk);
      cancel <= 1'b0;
      @(negedge clk);
      if (done !== 1'b0) begin
         abort_run($sformatf("row %0d: done stayed high longer than one cycle", idx));
      end
   endtask

   initial begin
      seed     = 32'h8c10_8661;
      reset    = 1'b1;
      start    = 1'b0;
      cmd      = '0;
      dividend = '0;
      divisor  = '0;
      cancel   = 1'b0;
      build_directed_rows();
      build_random_rows(48);
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (done !== 1'b0) begin
         abort_run("done was not low right after reset");
      end
      foreach (rows[i]) begin
         apply_row(rows[i], i);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
rtl/div_pkg.sv
rtl/div_control.sv
rtl/div_smallnum.sv
rtl/div_datapath.sv
rtl/div_result.sv
rtl/div_top.sv
verif/div_tb.sv

/* Bender.yml */
package:
  name: div

sources:
  - rtl/div_pkg.sv
  - rtl/div_control.sv
  - rtl/div_smallnum.sv
  - rtl/div_datapath.sv
  - rtl/div_result.sv
  - rtl/div_top.sv
  - target: test
    files:
      - verif/div_tb.sv
